/* verilog/fir_pkg.sv */
//////////////////////////////////////////////////
// Datapath types shared by the FIR filter stages
//////////////////////////////////////////////////

package fir_pkg;

    // Input sample and coefficient widths
    localparam int SAMPLE_W = 16;
    localparam int COEFF_W  = 16;

    // A full product needs the sum of both operand widths
    localparam int PRODUCT_W = SAMPLE_W + COEFF_W;

    // Eight guard bits above the product width cover up to 256 taps
    localparam int ACC_W = 40;

    // Signed input sample as it arrives on the input stream
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Signed coefficient as stored in the coefficient bank
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // Full-precision product of one tap
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // Sum over all taps, which leaves on the output stream
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* verilog/fir_cfg_pkg.sv */
//////////////////////////////////////////////////
// Register map and limits of the FIR configuration port
//////////////////////////////////////////////////

package fir_cfg_pkg;

    // Address and data of one configuration write
    typedef logic [7:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Tap index and active tap count
    typedef logic [7:0] tap_idx_t;

    // Register addresses
    localparam cfg_addr_t ADDR_N_TAPS   = 8'd0;
    localparam cfg_addr_t ADDR_TAP_BASE = 8'd16;

    // Smallest tap count accepted on a write and the largest delay line supported
    localparam int TAP_COUNT_MIN = 1;
    localparam int TAP_COUNT_MAX = 64;

    // Width of a coefficient index for a bank of n taps
    function automatic int idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

/* verilog/tap_cfg_if.sv */
//////////////////////////////////////////////////
// Coefficient writes and tap count, register block to multiplier
//////////////////////////////////////////////////

interface tap_cfg_if #(
    parameter int N_TAPS_MAX = 8
);
    import fir_pkg::*;
    import fir_cfg_pkg::*;

    localparam int IDX_W = idx_width(N_TAPS_MAX);

    // One-cycle strobe with the coefficient that goes into the bank
    logic             tap_write;
    logic [IDX_W-1:0] tap_idx;
    coeff_t           tap_data;

    // Active tap count, held as a level
    tap_idx_t         n_taps;

    modport source (
        output tap_write,
        output tap_idx,
        output tap_data,
        output n_taps
    );

    modport sink (
        input tap_write,
        input tap_idx,
        input tap_data,
        input n_taps
    );

endinterface

/* verilog/fir_cfg_regs.sv */
//////////////////////////////////////////////////
// Decodes configuration writes into tap count and coefficient strobes
//////////////////////////////////////////////////

module fir_cfg_regs #(
    parameter int N_TAPS_MAX = 8
)(
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   cfg_write,
    input  fir_cfg_pkg::cfg_addr_t cfg_addr,
    input  fir_cfg_pkg::cfg_data_t cfg_wdata,
    tap_cfg_if.source              tap_cfg
);
    import fir_pkg::*;
    import fir_cfg_pkg::*;

    localparam int IDX_W = idx_width(N_TAPS_MAX);

    // Tap count used after reset and as the clamp value
    localparam tap_idx_t N_TAPS_TOP =
        tap_idx_t'((N_TAPS_MAX < TAP_COUNT_MAX) ? N_TAPS_MAX : TAP_COUNT_MAX);

    cfg_addr_t tap_offset;
    logic      hit_n_taps;
    logic      hit_tap;

    assign tap_offset = cfg_addr - ADDR_TAP_BASE;
    assign hit_n_taps = cfg_write && (cfg_addr == ADDR_N_TAPS);
    assign hit_tap    = cfg_write && (cfg_addr >= ADDR_TAP_BASE)
                        && (tap_offset < N_TAPS_MAX);

    // Zero is ignored, anything above the delay line length is clamped
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tap_cfg.n_taps <= N_TAPS_TOP;
        end else if (hit_n_taps && (cfg_wdata >= TAP_COUNT_MIN)) begin
            if (cfg_wdata > N_TAPS_TOP) begin
                tap_cfg.n_taps <= N_TAPS_TOP;
            end else begin
                tap_cfg.n_taps <= tap_idx_t'(cfg_wdata);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tap_cfg.tap_write <= 1'b0;
        end else begin
            tap_cfg.tap_write <= hit_tap;
        end
    end

    // Index and value only matter while the strobe is high
    always_ff @(posedge clock) begin
        if (hit_tap) begin
            tap_cfg.tap_idx  <= tap_offset[IDX_W-1:0];
            tap_cfg.tap_data <= coeff_t'(cfg_wdata);
        end
    end

endmodule

/* verilog/fir_delay_line.sv */
//////////////////////////////////////////////////
// Input stage that shifts accepted samples into the tap window
//////////////////////////////////////////////////

module fir_delay_line #(
    parameter int N_TAPS_MAX = 8
)(
    input  logic             clock,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             in_valid,
    output logic             in_ready,
    input  fir_pkg::sample_t in_data,
    output fir_pkg::sample_t window [N_TAPS_MAX],
    output logic             window_valid
);

    // The whole pipeline moves together, so the input is ready whenever it advances
    assign in_ready = advance;

    // Marks a window that changed on the last advance
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            window_valid <= 1'b0;
        end else if (advance) begin
            window_valid <= in_valid;
        end
    end

    // Newest sample sits at position 0, a bubble leaves the window alone
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < N_TAPS_MAX; k++) begin
                window[k] <= '0;
            end
        end else if (advance && in_valid) begin
            window[0] <= in_data;
            for (int k = 1; k < N_TAPS_MAX; k++) begin
                window[k] <= window[k-1];
            end
        end
    end

endmodule

/* verilog/fir_multiply.sv */
//////////////////////////////////////////////////
// Coefficient bank and one registered multiplier per tap
//////////////////////////////////////////////////

module fir_multiply #(
    parameter int N_TAPS_MAX = 8
)(
    input  logic              clock,
    input  logic              arst_n,
    input  logic              advance,
    tap_cfg_if.sink           tap_cfg,
    input  fir_pkg::sample_t  window [N_TAPS_MAX],
    input  logic              window_valid,
    output fir_pkg::product_t products [N_TAPS_MAX],
    output logic              products_valid
);
    import fir_pkg::*;

    coeff_t coeffs [N_TAPS_MAX];

    // Bank is written one coefficient per strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < N_TAPS_MAX; k++) begin
                coeffs[k] <= '0;
            end
        end else if (tap_cfg.tap_write) begin
            coeffs[tap_cfg.tap_idx] <= tap_cfg.tap_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            products_valid <= 1'b0;
        end else if (advance) begin
            products_valid <= window_valid;
        end
    end

    // Taps at or beyond the active count contribute nothing to the sum
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int k = 0; k < N_TAPS_MAX; k++) begin
                if (k < tap_cfg.n_taps) begin
                    products[k] <= product_t'(window[k]) * product_t'(coeffs[k]);
                end else begin
                    products[k] <= '0;
                end
            end
        end
    end

endmodule

/* verilog/fir_adder_tree.sv */
//////////////////////////////////////////////////
// Output stage that sums the tap products and owns the pipeline advance
//////////////////////////////////////////////////

module fir_adder_tree #(
    parameter int N_TAPS_MAX = 8
)(
    input  logic              clock,
    input  logic              arst_n,
    input  fir_pkg::product_t products [N_TAPS_MAX],
    input  logic              products_valid,
    output logic              advance,
    output logic              out_valid,
    input  logic              out_ready,
    output fir_pkg::acc_t     out_data
);
    import fir_pkg::*;

    acc_t sum;

    // Every stage moves when the output register is empty or being drained
    assign advance = !out_valid || out_ready;

    // Each product is sign-extended to full width before it is added
    always_comb begin
        sum = '0;
        for (int k = 0; k < N_TAPS_MAX; k++) begin
            sum = sum + acc_t'(products[k]);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= products_valid;
        end
    end

    // Result stays put while the consumer holds out_ready low
    always_ff @(posedge clock) begin
        if (advance) begin
            out_data <= sum;
        end
    end

endmodule

/* verilog/fir_top.sv */
//////////////////////////////////////////////////
// FIR filter top: config port, sample stream in, sum stream out
//////////////////////////////////////////////////

module fir_top #(
    parameter int N_TAPS_MAX = 8
)(
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   cfg_write,
    input  fir_cfg_pkg::cfg_addr_t cfg_addr,
    input  fir_cfg_pkg::cfg_data_t cfg_wdata,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  fir_pkg::sample_t       in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fir_pkg::acc_t          out_data
);
    import fir_pkg::*;

    sample_t  window [N_TAPS_MAX];
    logic     window_valid;
    product_t products [N_TAPS_MAX];
    logic     products_valid;
    logic     advance;

    tap_cfg_if #(
        .N_TAPS_MAX(N_TAPS_MAX)
    ) tap_cfg ();

    fir_cfg_regs #(
        .N_TAPS_MAX(N_TAPS_MAX)
    ) cfg_regs_i (
        .clock(clock),
        .arst_n(arst_n),
        .cfg_write(cfg_write),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .tap_cfg(tap_cfg.source)
    );

    fir_delay_line #(
        .N_TAPS_MAX(N_TAPS_MAX)
    ) delay_line_i (
        .clock(clock),
        .arst_n(arst_n),
        .advance(advance),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .window(window),
        .window_valid(window_valid)
    );

    fir_multiply #(
        .N_TAPS_MAX(N_TAPS_MAX)
    ) multiply_i (
        .clock(clock),
        .arst_n(arst_n),
        .advance(advance),
        .tap_cfg(tap_cfg.sink),
        .window(window),
        .window_valid(window_valid),
        .products(products),
        .products_valid(products_valid)
    );

    // The last stage closes the loop by driving advance back upstream
    fir_adder_tree #(
        .N_TAPS_MAX(N_TAPS_MAX)
    ) adder_tree_i (
        .clock(clock),
        .arst_n(arst_n),
        .products(products),
        .products_valid(products_valid),
        .advance(advance),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

endmodule

/* tests/fir_tb_clock.sv */
//////////////////////////////////////////////////
// Testbench clock and active-low reset source
//////////////////////////////////////////////////

module fir_tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
)(
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    // Reset releases on a rising edge after the hold period
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

/* tests/fir_chk.sv */
//////////////////////////////////////////////////
// Stream protocol assertions, bound into the FIR top level
//////////////////////////////////////////////////

module fir_chk (
    input logic          clock,
    input logic          arst_n,
    input logic          in_ready,
    input logic          out_valid,
    input logic          out_ready,
    input fir_pkg::acc_t out_data
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // A stalled result holds its value until the consumer takes it
    stall_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
        fail_count++;
        $error("output stream changed while stalled");
    end

    reset_quiet: assert property (@(posedge clock) !arst_n |-> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high during reset");
    end

    // The whole pipeline freezes with the output, input side included
    stall_blocks_input: assert property (@(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |-> !in_ready)
    else begin
        fail_count++;
        $error("in_ready high while the output is stalled");
    end

endmodule

/* tests/fir_tb.sv */
//////////////////////////////////////////////////
// FIR testbench with config writes, sample streams and a reference convolution
//////////////////////////////////////////////////

module fir_tb;
    import fir_pkg::*;
    import fir_cfg_pkg::*;

    localparam int N_TAPS        = 8;
    localparam int SEND_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 500;
    localparam int RESET_TIMEOUT = 20;

    logic        clock;
    logic        arst_n;
    logic        cfg_write;
    cfg_addr_t   cfg_addr;
    cfg_data_t   cfg_wdata;
    logic        in_valid;
    logic        in_ready;
    sample_t     in_data;
    logic        out_valid;
    logic        out_ready;
    acc_t        out_data;

    // Reference model state
    coeff_t      ref_coeff [N_TAPS];
    sample_t     history [N_TAPS];
    int          ref_n_taps;
    acc_t        expect_q [$];
    logic        random_ready;

    fir_tb_clock #(.PERIOD(4), .RESET_CYCLES(5)) clock_i (
        .clock(clock),
        .arst_n(arst_n)
    );

    fir_top #(.N_TAPS_MAX(N_TAPS)) fir_top_i (
        .clock(clock),
        .arst_n(arst_n),
        .cfg_write(cfg_write),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

    bind fir_top fir_chk chk_i (
        .clock(clock),
        .arst_n(arst_n),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_out(input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("error: time %0t expected %0d actual %0d",
                               $time, expected, actual));
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("error: time %0t %s expected %b actual %b",
                               $time, what, expected, actual));
        end
    endtask

    // Convolution over the active taps where history[0] is the newest sample
    function automatic acc_t ref_sum();
        longint total;
        total = 0;
        for (int k = 0; k < ref_n_taps; k++) begin
            total += longint'(ref_coeff[k]) * longint'(history[k]);
        end
        return acc_t'(total);
    endfunction

    // Every input transfer produces exactly one expected result
    always @(posedge clock) begin
        if (arst_n && in_valid && in_ready) begin
            for (int k = N_TAPS - 1; k > 0; k--) begin
                history[k] = history[k-1];
            end
            history[0] = in_data;
            expect_q.push_back(ref_sum());
        end
    end

    always @(posedge clock) begin
        if (arst_n && out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
                fail_run("an output transfer arrived with no result expected");
            end else begin
                check_out(expect_q.pop_front(), out_data);
            end
        end
    end

    // The consumer is ready about two cycles out of three when randomized
    always @(posedge clock) begin
        if (random_ready) begin
            out_ready <= ($urandom % 3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
        // Zero leaves the count alone and large values saturate at the delay line length
        if (addr == ADDR_N_TAPS) begin
            if (data != 0) begin
                ref_n_taps = (data > N_TAPS) ? N_TAPS : int'(data);
            end
        end else if (addr >= ADDR_TAP_BASE && addr < ADDR_TAP_BASE + N_TAPS) begin
            ref_coeff[addr - ADDR_TAP_BASE] = coeff_t'(data);
        end
        // Coefficients need two cycles before samples may use them
        repeat (3) @(posedge clock);
    endtask

    task automatic send_sample(input sample_t s);
        int cycles;
        cycles = 0;
        in_valid <= 1'b1;
        in_data  <= s;
        @(posedge clock);
        while (!in_ready && cycles < SEND_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (!in_ready) begin
            fail_run("an input sample was not accepted before the timeout");
        end
    endtask

    task automatic send_burst(input int count, input bit bubbles);
        int gap;
        for (int i = 0; i < count; i++) begin
            if (bubbles) begin
                gap = $urandom % 3;
                in_valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            send_sample(sample_t'($urandom));
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        in_valid <= 1'b0;
        random_ready <= 1'b0;
        while (expect_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            fail_run("results were still missing when the drain timeout expired");
        end
        repeat (2) @(posedge clock);
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h6ba3));
        cfg_write <= 1'b0;
        cfg_addr  <= '0;
        cfg_wdata <= '0;
        in_valid  <= 1'b0;
        in_data   <= '0;
        out_ready <= 1'b1;
        random_ready <= 1'b0;
        ref_n_taps = N_TAPS;
        for (int k = 0; k < N_TAPS; k++) begin
            ref_coeff[k] = '0;
            history[k] = '0;
        end

        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            fail_run("reset was never released");
        end
        @(posedge clock);
        check_ready(1'b1, in_ready, "in_ready after reset");
        check_ready(1'b0, out_valid, "out_valid after reset");

        // Zero coefficients give zero outputs
        send_burst(12, 1'b0);
        drain();

        // Impulse response with alternating signs so every tap is distinct
        write_cfg(ADDR_N_TAPS, cfg_data_t'(N_TAPS));
        for (int k = 0; k < N_TAPS; k++) begin
            write_cfg(cfg_addr_t'(ADDR_TAP_BASE + k),
                      cfg_data_t'((k % 2 == 0) ? (k + 1) * 250 : -(k + 1) * 250));
        end
        for (int i = 0; i < N_TAPS; i++) begin
            send_sample('0);
        end
        send_sample(sample_t'(1));
        for (int i = 0; i < N_TAPS; i++) begin
            send_sample('0);
        end
        drain();

        // Of these tap count writes the middle one is ignored and the last one clamps
        write_cfg(ADDR_N_TAPS, cfg_data_t'(3));
        send_burst(20, 1'b0);
        drain();
        write_cfg(ADDR_N_TAPS, cfg_data_t'(0));
        send_burst(20, 1'b0);
        drain();
        write_cfg(ADDR_N_TAPS, cfg_data_t'(200));
        send_burst(20, 1'b0);
        drain();

        // Random coefficients with a continuous stream
        for (int k = 0; k < N_TAPS; k++) begin
            write_cfg(cfg_addr_t'(ADDR_TAP_BASE + k), cfg_data_t'($urandom));
        end
        send_burst(300, 1'b0);
        drain();

        // Bubbles on the input and back-pressure on the output
        random_ready <= 1'b1;
        send_burst(300, 1'b1);
        drain();

        if (expect_q.size() == 0 && fir_top_i.chk_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("protocol assertions failed or results are missing at the end");
        end
    end

endmodule

/* flist.f */
verilog/fir_pkg.sv
verilog/fir_cfg_pkg.sv
verilog/tap_cfg_if.sv
verilog/fir_cfg_regs.sv
verilog/fir_delay_line.sv
verilog/fir_multiply.sv
verilog/fir_adder_tree.sv
verilog/fir_top.sv
tests/fir_tb_clock.sv
tests/fir_chk.sv
tests/fir_tb.sv

/* Makefile */
# Verilator build and run for the FIR filter testbench

TOP   = fir_tb
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f flist.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

# The run passes only if the log holds the pass line
run: compile
	./$(BUILD)/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
